// File: design/axi_pkg.sv
package axi_pkg;

  // Master-side ID width
  localparam int axi_id_bits = 4;

  // Low slave-side ID bits that pick the master
  localparam int id_sel_bits = 4;

  // Slave-side ID carries the master index below the master ID
  localparam int axi_ids_bits = axi_id_bits + id_sel_bits;

  localparam int num_slaves_default  = 3;
  localparam int num_masters_default = 2;

  // B-channel response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  // Response as seen on a slave port
  typedef struct packed {
    logic [axi_ids_bits-1:0] id;
    resp_t                   resp;
  } b_slave_t;

  // Response as seen on a master port
  typedef struct packed {
    logic [axi_id_bits-1:0] id;
    resp_t                  resp;
  } b_master_t;

  // Arbiter lock, one state per slave plus idle
  typedef enum logic [1:0] {
    LOCK_NO,
    LOCK_S0,
    LOCK_S1,
    LOCK_S2
  } lock_t;

  typedef logic [1:0] master_idx_t;

  // Index for responses that belong to no master
  localparam master_idx_t master_none = 2'd3;

  // Map the low ID bits to a master index
  function automatic master_idx_t master_sel(input logic [id_sel_bits-1:0] sel);
    master_idx_t idx;
    if (sel < id_sel_bits'(num_masters_default)) begin
      idx = master_idx_t'(sel);
    end else begin
      idx = master_none;
    end
    return idx;
  endfunction

endpackage

// File: design/b_reg_slice.sv
module b_reg_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // Main entry drives the output
  logic     main_valid;
  payload_t main_data;

  // Skid entry catches a transfer while the output stalls
  logic     skid_valid;
  payload_t skid_data;

  logic in_fire;
  logic main_load;
  logic main_valid_next;
  logic skid_valid_next;

  assign in_fire = in_valid & in_ready;

  // Main entry is free when empty or draining this cycle
  assign main_load = ~main_valid | out_ready;

  always_comb begin
    if (main_load) begin
      main_valid_next = skid_valid | in_fire;
      skid_valid_next = 1'b0;
    end else begin
      main_valid_next = 1'b1;
      skid_valid_next = skid_valid | in_fire;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      main_valid <= main_valid_next;
      skid_valid <= skid_valid_next;
      // Registered ready, high while the skid entry is empty
      in_ready   <= ~skid_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      // Skid entry is older, so it goes first
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (in_fire) begin
        main_data <= in_data;
      end
    end
    if (in_fire && !main_load) begin
      skid_data <= in_data;
    end
  end

  assign out_valid = main_valid;
  assign out_data  = main_data;

endmodule

// File: design/b_slave_arbiter.sv
module b_slave_arbiter #(
  parameter int num_slaves = axi_pkg::num_slaves_default
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [num_slaves-1:0] arb_valid,
  output logic [num_slaves-1:0] arb_ready,
  input  axi_pkg::b_slave_t     arb_resp [num_slaves],
  output logic                  sel_valid,
  input  logic                  sel_ready,
  output axi_pkg::b_slave_t     sel_resp
);
  import axi_pkg::*;

  localparam int lock_bits = $bits(lock_t);

  lock_t                lock_q;
  lock_t                lock_next;
  logic                 pick_valid;
  logic [lock_bits-1:0] pick_idx;
  logic [lock_bits-1:0] lock_idx;
  b_slave_t             resp_q;

  // Fixed priority, slave 0 wins
  always_comb begin
    pick_valid = 1'b0;
    pick_idx   = '0;
    for (int i = num_slaves - 1; i >= 0; i--) begin
      if (arb_valid[i]) begin
        pick_valid = 1'b1;
        pick_idx   = lock_bits'(i);
      end
    end
  end

  // Slave index held by the current lock
  assign lock_idx = lock_q - 1'b1;

  always_comb begin
    lock_next = lock_q;
    if (lock_q == LOCK_NO) begin
      if (pick_valid) begin
        lock_next = lock_t'(pick_idx + 1'b1);
      end
    end else if (sel_ready) begin
      // Response taken downstream
      lock_next = LOCK_NO;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= LOCK_NO;
    end else begin
      lock_q <= lock_next;
    end
  end

  // Capture the winner on the locking edge
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      resp_q <= '0;
    end else if (lock_q == LOCK_NO && pick_valid) begin
      resp_q <= arb_resp[pick_idx];
    end
  end

  // Only the locked slave sees ready
  always_comb begin
    arb_ready = '0;
    for (int i = 0; i < num_slaves; i++) begin
      if (lock_q != LOCK_NO && lock_idx == lock_bits'(i)) begin
        arb_ready[i] = sel_ready;
      end
    end
  end

  assign sel_valid = (lock_q != LOCK_NO);
  assign sel_resp  = resp_q;

endmodule

// File: design/b_master_router.sv
module b_master_router #(
  parameter int num_masters = axi_pkg::num_masters_default
) (
  input  logic                   sel_valid,
  output logic                   sel_ready,
  input  axi_pkg::b_slave_t      sel_resp,
  output logic [num_masters-1:0] rt_valid,
  input  logic [num_masters-1:0] rt_ready,
  output axi_pkg::b_master_t     rt_resp
);
  import axi_pkg::*;

  master_idx_t sel_idx;
  logic        known;

  // Master index from the low ID bits
  assign sel_idx = master_sel(sel_resp.id[id_sel_bits-1:0]);

  // Upper ID bits become the master-side ID
  assign rt_resp.id   = sel_resp.id[axi_ids_bits-1:id_sel_bits];
  assign rt_resp.resp = sel_resp.resp;

  always_comb begin
    rt_valid  = '0;
    sel_ready = 1'b0;
    known     = 1'b0;
    for (int k = 0; k < num_masters; k++) begin
      if (sel_idx == master_idx_t'(k)) begin
        known       = 1'b1;
        rt_valid[k] = sel_valid;
        sel_ready   = rt_ready[k];
      end
    end
    // No such master, take the response and drop it
    if (!known) begin
      sel_ready = 1'b1;
    end
  end

endmodule

// File: design/b_return_path.sv
module b_return_path #(
  parameter int num_slaves  = axi_pkg::num_slaves_default,
  parameter int num_masters = axi_pkg::num_masters_default
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [num_slaves-1:0]  s_valid,
  output logic [num_slaves-1:0]  s_ready,
  input  axi_pkg::b_slave_t      s_resp [num_slaves],
  output logic [num_masters-1:0] m_valid,
  input  logic [num_masters-1:0] m_ready,
  output axi_pkg::b_master_t     m_resp [num_masters]
);
  import axi_pkg::*;

  logic [num_slaves-1:0]  arb_valid;
  logic [num_slaves-1:0]  arb_ready;
  b_slave_t               arb_resp [num_slaves];

  logic                   sel_valid;
  logic                   sel_ready;
  b_slave_t               sel_resp;

  logic [num_masters-1:0] rt_valid;
  logic [num_masters-1:0] rt_ready;
  b_master_t              rt_resp;

  // Slave side slices
  for (genvar i = 0; i < num_slaves; i++) begin : g_slave
    b_reg_slice #(
      .payload_t(b_slave_t)
    ) u_slice (
      .clk      (clk),
      .rstn     (rstn),
      .in_valid (s_valid[i]),
      .in_ready (s_ready[i]),
      .in_data  (s_resp[i]),
      .out_valid(arb_valid[i]),
      .out_ready(arb_ready[i]),
      .out_data (arb_resp[i])
    );
  end

  b_slave_arbiter #(
    .num_slaves(num_slaves)
  ) u_arbiter (
    .clk      (clk),
    .rstn     (rstn),
    .arb_valid(arb_valid),
    .arb_ready(arb_ready),
    .arb_resp (arb_resp),
    .sel_valid(sel_valid),
    .sel_ready(sel_ready),
    .sel_resp (sel_resp)
  );

  b_master_router #(
    .num_masters(num_masters)
  ) u_router (
    .sel_valid(sel_valid),
    .sel_ready(sel_ready),
    .sel_resp (sel_resp),
    .rt_valid (rt_valid),
    .rt_ready (rt_ready),
    .rt_resp  (rt_resp)
  );

  // Master side slices share the routed payload
  for (genvar k = 0; k < num_masters; k++) begin : g_master
    b_reg_slice #(
      .payload_t(b_master_t)
    ) u_slice (
      .clk      (clk),
      .rstn     (rstn),
      .in_valid (rt_valid[k]),
      .in_ready (rt_ready[k]),
      .in_data  (rt_resp),
      .out_valid(m_valid[k]),
      .out_ready(m_ready[k]),
      .out_data (m_resp[k])
    );
  end

endmodule

// File: bench/b_return_path_assertions.sv
module b_return_path_assertions #(
  parameter int num_slaves  = axi_pkg::num_slaves_default,
  parameter int num_masters = axi_pkg::num_masters_default
) (
  input logic                   clk,
  input logic                   rstn,
  input logic [num_masters-1:0] m_valid,
  input logic [num_masters-1:0] m_ready,
  input axi_pkg::b_master_t     m_resp [num_masters],
  input logic [num_slaves-1:0]  arb_valid,
  input logic [num_slaves-1:0]  arb_ready,
  input axi_pkg::b_slave_t      arb_resp [num_slaves],
  input logic                   sel_valid,
  input axi_pkg::b_slave_t      sel_resp,
  input axi_pkg::lock_t         lock
);
  import axi_pkg::*;

  int lock_slave;

  // Slave held by the lock
  assign lock_slave = int'(lock) - 1;

  for (genvar k = 0; k < num_masters; k++) begin : g_master
    hold_valid: assert property (@(posedge clk) disable iff (!rstn)
      m_valid[k] && !m_ready[k] |=> m_valid[k])
      else $error("master %0d dropped valid before ready", k);

    hold_payload: assert property (@(posedge clk) disable iff (!rstn)
      m_valid[k] && !m_ready[k] |=> $stable(m_resp[k]))
      else $error("master %0d changed its payload before ready", k);
  end

  one_ready: assert property (@(posedge clk) disable iff (!rstn) $onehot0(arb_ready))
    else $error("more than one slave sees ready at once");

  // Locked slave still holds the captured response in its slice
  locked_held: assert property (@(posedge clk) disable iff (!rstn)
    sel_valid |-> arb_valid[lock_slave] && arb_resp[lock_slave] == sel_resp)
    else $error("arbiter offers a response its slave no longer holds");

endmodule

bind b_return_path b_return_path_assertions #(
  .num_slaves (num_slaves),
  .num_masters(num_masters)
) u_assertions (
  .clk      (clk),
  .rstn     (rstn),
  .m_valid  (m_valid),
  .m_ready  (m_ready),
  .m_resp   (m_resp),
  .arb_valid(arb_valid),
  .arb_ready(arb_ready),
  .arb_resp (arb_resp),
  .sel_valid(sel_valid),
  .sel_resp (sel_resp),
  .lock     (u_arbiter.lock_q)
);

// File: bench/b_return_path_tb.sv
module b_return_path_tb;
  import axi_pkg::*;

  localparam int num_slaves  = 3;
  localparam int num_masters = 2;
  // About four times the summed length of all tests
  localparam int cycle_limit = 2000;

  logic                   clk;
  logic                   rstn;
  logic [num_slaves-1:0]  s_valid = '0;
  logic [num_slaves-1:0]  s_ready;
  b_slave_t               s_resp [num_slaves] = '{default: '0};
  logic [num_masters-1:0] m_valid;
  logic [num_masters-1:0] m_ready = '0;
  b_master_t              m_resp [num_masters];

  // Responses not yet taken by a slave port
  b_slave_t  pending [num_slaves][$];
  // Expected payloads per master and source slave
  b_master_t expected [num_masters][num_slaves][$];
  b_master_t received [num_masters][$];

  logic [num_slaves-1:0] s_fire = '0;
  logic stall_seen = 1'b0;
  int   ready_mode = 0;
  int   seed = 32'ha4ebd826;
  int   seq [num_slaves][num_masters];
  int   cycles = 0;
  int   errors = 0;
  int   start_errors = 0;
  int   tests_run = 0;
  int   got_total = 0;

  b_return_path #(
    .num_slaves (num_slaves),
    .num_masters(num_masters)
  ) DUT (
    .clk    (clk),
    .rstn   (rstn),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_resp (s_resp),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_resp (m_resp)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, responses are still missing", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Handshakes sampled mid-cycle while inputs are stable
  always @(negedge clk) begin
    for (int i = 0; i < num_slaves; i++) begin
      s_fire[i] = rstn & s_valid[i] & s_ready[i];
      if (rstn && s_valid[i] && !s_ready[i]) begin
        stall_seen = 1'b1;
      end
    end
    for (int k = 0; k < num_masters; k++) begin
      if (rstn && m_valid[k] && m_ready[k]) begin
        received[k].push_back(m_resp[k]);
        got_total = got_total + 1;
      end
    end
  end

  always @(posedge clk) begin
    #2;
    for (int i = 0; i < num_slaves; i++) begin
      if (s_fire[i]) begin
        pending[i].delete(0);
      end
      if (pending[i].size() > 0) begin
        s_valid[i] = 1'b1;
        s_resp[i]  = pending[i][0];
      end else begin
        s_valid[i] = 1'b0;
        s_resp[i]  = '0;
      end
    end
    for (int k = 0; k < num_masters; k++) begin
      case (ready_mode)
        0:       m_ready[k] = 1'b1;
        1:       m_ready[k] = 1'b0;
        default: m_ready[k] = 1'($random(seed));
      endcase
    end
  end

  // Slave and sequence sit above the master index in the ID
  task automatic queue_resp(input int slave, input int master);
    b_slave_t  r;
    b_master_t e;
    r.id   = {2'(slave), 2'(seq[slave][master]), 4'(master)};
    r.resp = resp_t'(2'(seq[slave][master] >> 2));
    e.id   = {2'(slave), 2'(seq[slave][master])};
    e.resp = r.resp;
    pending[slave].push_back(r);
    expected[master][slave].push_back(e);
    seq[slave][master] = (seq[slave][master] + 1) % 16;
  endtask

  task automatic queue_drop(input int slave, input int sel);
    b_slave_t r;
    r.id   = {4'hf, 4'(sel)};
    r.resp = SLVERR;
    pending[slave].push_back(r);
  endtask

  task automatic check_master(input string name, input b_master_t exp, input b_master_t act);
    if (exp !== act) begin
      errors++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("Fail %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic wait_for_count(input int want);
    while (got_total < want) begin
      @(posedge clk);
    end
    // Room for a late duplicate to show up
    repeat (6) @(posedge clk);
  endtask

  task automatic compare_received(input string name);
    b_master_t act;
    int        src;
    for (int k = 0; k < num_masters; k++) begin
      while (received[k].size() > 0) begin
        act = received[k].pop_front();
        src = int'(act.id[axi_id_bits-1:2]);
        if (src >= num_slaves || expected[k][src].size() == 0) begin
          errors++;
          $display("%s: master %0d got a response %h that was never sent", name, k, act);
        end else begin
          check_master(name, expected[k][src].pop_front(), act);
        end
      end
      for (int s = 0; s < num_slaves; s++) begin
        if (expected[k][s].size() > 0) begin
          errors++;
          $display("%s: %0d responses from slave %0d never reached master %0d",
                   name, expected[k][s].size(), s, k);
          expected[k][s].delete();
        end
      end
    end
  endtask

  task automatic start_test();
    got_total    = 0;
    start_errors = errors;
    ready_mode   = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("%s finished with %0d errors", name, errors - start_errors);
  endtask

  task automatic test_single_routing();
    start_test();
    for (int s = 0; s < num_slaves; s++) begin
      for (int m = 0; m < num_masters; m++) begin
        queue_resp(s, m);
        wait_for_count(s * num_masters + m + 1);
      end
    end
    check_count("single_routing count", num_slaves * num_masters, got_total);
    compare_received("single_routing");
    end_test("single_routing");
  endtask

  task automatic test_priority();
    start_test();
    // Queued in one time step to go valid together
    for (int s = 0; s < num_slaves; s++) begin
      queue_resp(s, 0);
    end
    wait_for_count(num_slaves);
    check_count("priority count", num_slaves, got_total);
    for (int n = 0; n < num_slaves; n++) begin
      if (received[0].size() > n) begin
        check_master("priority order", expected[0][n][0], received[0][n]);
      end
    end
    compare_received("priority");
    end_test("priority");
  endtask

  task automatic test_backpressure();
    start_test();
    ready_mode = 1;
    stall_seen = 1'b0;
    for (int n = 0; n < 4; n++) begin
      for (int s = 0; s < num_slaves; s++) begin
        queue_resp(s, (n + s) % num_masters);
      end
    end
    repeat (20) @(posedge clk);
    check_count("backpressure stall", 1, int'(stall_seen));
    ready_mode = 0;
    wait_for_count(12);
    check_count("backpressure count", 12, got_total);
    compare_received("backpressure");
    end_test("backpressure");
  endtask

  task automatic test_unknown_master();
    start_test();
    queue_drop(1, 5);
    queue_resp(1, 0);
    wait_for_count(1);
    check_count("unknown_master count", 1, got_total);
    compare_received("unknown_master");
    end_test("unknown_master");
  endtask

  task automatic test_random_stream();
    int s;
    int m;
    start_test();
    ready_mode = 2;
    for (int n = 0; n < 200; n++) begin
      s = ($random(seed) & 32'h7fff_ffff) % num_slaves;
      m = ($random(seed) & 32'h7fff_ffff) % num_masters;
      queue_resp(s, m);
    end
    wait_for_count(200);
    check_count("random_stream count", 200, got_total);
    compare_received("random_stream");
    end_test("random_stream");
  endtask

  initial begin
    rstn = 1'b0;
    for (int s = 0; s < num_slaves; s++) begin
      for (int m = 0; m < num_masters; m++) begin
        seq[s][m] = 0;
      end
    end
    repeat (2) @(posedge clk);
    #2 rstn = 1'b1;
    @(posedge clk);
    test_single_routing();
    test_priority();
    test_backpressure();
    test_unknown_master();
    test_random_stream();
    $display("Tests run %0d, errors %0d, cycles %0d", tests_run, errors, cycles);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: b_return_path.f
design/axi_pkg.sv
design/b_reg_slice.sv
design/b_slave_arbiter.sv
design/b_master_router.sv
design/b_return_path.sv
bench/b_return_path_assertions.sv
bench/b_return_path_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the B-channel return path testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module b_return_path_tb -f b_return_path.f \
  -o b_return_path_sim > build.log 2>&1 &&
  ./obj_dir/b_return_path_sim > sim.log 2>&1 ||
  { echo "build or simulation ended with an error, see build.log and sim.log"; }

grep -q "^TEST PASS$" sim.log &&
  { echo "simulation passed"; exit 0; } ||
  { echo "simulation failed"; exit 1; }
